// ==== all.f ====
rtl/decode_pkg.sv
rtl/instr_classify.sv
rtl/issue_control.sv
rtl/alu_operand_prep.sv
rtl/ls_operand_prep.sv
rtl/decode_issue.sv
bench/decode_assert.sv
bench/decode_checker.sv
bench/decode_issue_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the decode and issue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f all.f --top-module decode_issue_tb

# simulation output goes to the terminal, the pass line decides the status
./obj_dir/Vdecode_issue_tb | tee /dev/stderr | grep -qx "Finished with no errors"

// ==== bench/decode_tests.txt ====
# instr pc valid flush rs1_data rs2_data rs1_conf rs2_conf ready | pop issue illegal
# alu_in1 alu_in2 sub op logic | ls_offset ls_base ls_store_data kind{load,store}, all hex
123452b7 00001000 1 0 aaaaaaaa 55555555 0 0 f 1 1 0 000000000 012345000 0 0 0 000 00000000 00000000 0
80000317 00001004 1 0 aaaaaaaa 55555555 0 0 f 1 1 0 000001004 180000000 0 0 0 000 00000000 00000000 0
fff08393 00001008 1 0 00000010 12345678 0 1 f 1 1 0 000000010 1ffffffff 0 0 0 000 00000000 00000000 0
40310433 0000100c 1 0 80000001 00000002 0 0 f 1 1 0 180000001 000000002 1 0 0 000 00000000 00000000 0
005234b3 00001010 1 0 fffffffe 80000000 0 0 f 1 1 0 0fffffffe 080000000 1 1 0 000 00000000 00000000 0
40735533 00001014 1 0 f0000000 00000004 0 0 f 1 1 0 1f0000000 000000004 0 2 0 000 00000000 00000000 0
00862583 00001018 1 0 00002000 deadbeef 0 0 f 1 2 0 000000000 000000000 0 0 0 008 00002000 deadbeef 2
12b6a223 0000101c 1 0 00003000 11111111 0 1 f 1 2 0 000000000 000000000 0 0 0 124 00003000 11111111 1
00100593 00001020 1 0 00000000 00000000 0 0 f 1 1 0 000000000 000000001 0 0 0 000 00000000 00000000 0
12b6a223 00001024 1 0 00003000 11111111 0 1 f 0 0 0 000000000 000000000 0 0 0 000 00000000 00000000 0
00208733 00001028 1 0 00000003 00000004 1 0 f 0 0 0 000000000 000000000 0 0 0 000 00000000 00000000 0
00208733 00001028 1 0 00000003 00000004 0 0 e 0 0 0 000000000 000000000 0 0 0 000 00000000 00000000 0
00208733 00001028 1 1 00000003 00000004 0 0 f 0 0 0 000000000 000000000 0 0 0 000 00000000 00000000 0
00208733 00001028 1 0 00000003 00000004 0 0 f 1 1 0 000000003 000000004 0 0 0 000 00000000 00000000 0
00208063 0000102c 1 0 00000001 00000001 0 0 f 1 4 0 000000000 000000000 0 0 0 000 00000000 00000000 0
000000ef 00001030 1 0 00000000 00000000 0 0 f 1 4 0 000000000 000000000 0 0 0 000 00000000 00000000 0
00000073 00001034 1 0 00000000 00000000 1 1 f 1 8 0 000000000 000000000 0 0 0 000 00000000 00000000 0
0000000f 00001038 1 0 00000000 00000000 0 0 f 1 8 0 000000000 000000000 0 0 0 000 00000000 00000000 0
023100b3 0000103c 1 0 00000000 00000000 0 0 f 0 0 1 000000000 000000000 0 0 0 000 00000000 00000000 0
0000007f 00001040 1 0 00000000 00000000 0 0 f 0 0 1 000000000 000000000 0 0 0 000 00000000 00000000 0
00000012 00001044 1 0 00000000 00000000 0 0 f 0 0 1 000000000 000000000 0 0 0 000 00000000 00000000 0

// ==== bench/decode_issue_tb.sv ====
//----------------------------------------------------------------------
// testbench for the decode and issue stage
// replays test vectors from a file, one per clock, and sums up errors
//----------------------------------------------------------------------
module decode_issue_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import decode_pkg::*;

    localparam int max_steps = 100;   // file lines the vector loop may take

    logic          clk;
    logic          rst;
    logic          instr_valid;
    instr_t        instruction;
    addr_t         pc;
    logic          flush;
    word_t         rs1_data;
    word_t         rs2_data;
    logic          rs1_conflict;
    logic          rs2_conflict;
    unit_vec_t     unit_ready;
    reg_addr_t     rs1_addr;
    reg_addr_t     rs2_addr;
    logic          pop;
    unit_vec_t     issue;
    unit_vec_t     start;
    logic          illegal;
    alu_operand_t  alu_in1;
    alu_operand_t  alu_in2;
    word_t         alu_shifter_in;
    logic          alu_subtract;
    logic          alu_arith;
    logic          alu_lshift;
    alu_logic_op_t alu_logic;
    alu_op_t       alu_op;
    ls_offset_t    ls_offset;
    word_t         ls_base;
    word_t         ls_store_data;
    fn3_t          ls_fn3;
    logic          ls_load;
    logic          ls_store;

    //------------------------------------------------------------------
    // expected values, handed to the checker
    //------------------------------------------------------------------
    logic          exp_pop;
    unit_vec_t     exp_issue;
    logic          exp_illegal;
    alu_operand_t  exp_in1;
    alu_operand_t  exp_in2;
    logic          exp_sub;
    logic [1:0]    exp_op;
    logic [1:0]    exp_logic;
    ls_offset_t    exp_offset;
    word_t         exp_base;
    word_t         exp_sdata;
    logic [1:0]    exp_kind;        // {load, store}

    int            issue_errors;
    int            operand_errors;
    int            other_errors;    // file and timeout problems
    int            fd;
    int            steps;
    int            fields;
    string         line;

    decode_issue decode_issue_i (.*);

    decode_checker checker_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // empty slot, nop word with valid low
    task automatic drive_idle();
        instr_valid  = 1'b0;
        instruction  = 32'h0000_0013;
        pc           = '0;
        flush        = 1'b0;
        rs1_data     = '0;
        rs2_data     = '0;
        rs1_conflict = 1'b0;
        rs2_conflict = 1'b0;
        unit_ready   = '1;
        exp_pop      = 1'b0;
        exp_issue    = '0;
        exp_illegal  = 1'b0;
    endtask

    initial begin
        drive_idle();
        other_errors = 0;
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        fd = $fopen("bench/decode_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test vector file bench/decode_tests.txt");
            other_errors++;
        end else begin
            steps = 0;
            while (!$feof(fd) && steps < max_steps) begin
                steps++;
                if ($fgets(line, fd) < 2 || line.getc(0) == "#")
                    continue;                   // blank or column notes
                @(negedge clk);
                fields = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    instruction, pc, instr_valid, flush, rs1_data, rs2_data,
                    rs1_conflict, rs2_conflict, unit_ready, exp_pop, exp_issue,
                    exp_illegal, exp_in1, exp_in2, exp_sub, exp_op, exp_logic,
                    exp_offset, exp_base, exp_sdata, exp_kind);
                if (fields != 21) begin
                    $display("malformed test vector line: %s", line);
                    other_errors++;
                    drive_idle();
                end
            end
            if (!$feof(fd)) begin
                $display("timeout: test vectors not finished after %0d lines", max_steps);
                other_errors++;
            end
            $fclose(fd);
        end

        // let the last start pulse and operands reach the checker
        @(negedge clk);
        drive_idle();
        repeat (2) @(posedge clk);

        $display("errors: %0d issue, %0d operand, %0d other",
                 issue_errors, operand_errors, other_errors);
        if (issue_errors + operand_errors + other_errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// ==== bench/decode_checker.sv ====
//----------------------------------------------------------------------
// checker for decode_issue
// compares strobes in the issue cycle, start and operands one cycle on
//----------------------------------------------------------------------
module decode_checker (
    input  logic                      clk,
    input  logic                      rst,
    input  decode_pkg::instr_t        instruction,
    input  decode_pkg::word_t         rs1_data,
    input  decode_pkg::reg_addr_t     rs1_addr,
    input  decode_pkg::reg_addr_t     rs2_addr,
    input  logic                      pop,
    input  decode_pkg::unit_vec_t     issue,
    input  decode_pkg::unit_vec_t     start,
    input  logic                      illegal,
    input  decode_pkg::alu_operand_t  alu_in1,
    input  decode_pkg::alu_operand_t  alu_in2,
    input  decode_pkg::word_t         alu_shifter_in,
    input  logic                      alu_subtract,
    input  logic                      alu_arith,
    input  logic                      alu_lshift,
    input  decode_pkg::alu_op_t       alu_op,
    input  decode_pkg::alu_logic_op_t alu_logic,
    input  decode_pkg::ls_offset_t    ls_offset,
    input  decode_pkg::word_t         ls_base,
    input  decode_pkg::word_t         ls_store_data,
    input  decode_pkg::fn3_t          ls_fn3,
    input  logic                      ls_load,
    input  logic                      ls_store,
    // expected values of the vector presented in this cycle
    input  logic                      exp_pop,
    input  decode_pkg::unit_vec_t     exp_issue,
    input  logic                      exp_illegal,
    input  decode_pkg::alu_operand_t  exp_in1,
    input  decode_pkg::alu_operand_t  exp_in2,
    input  logic                      exp_sub,
    input  logic [1:0]                exp_op,
    input  logic [1:0]                exp_logic,
    input  decode_pkg::ls_offset_t    exp_offset,
    input  decode_pkg::word_t         exp_base,
    input  decode_pkg::word_t         exp_sdata,
    input  logic [1:0]                exp_kind,
    output int                        issue_errors,
    output int                        operand_errors
);
    timeunit 1ns;
    timeprecision 1ps;
    import decode_pkg::*;

    // expectations of the previous cycle
    unit_vec_t    prev_issue;
    alu_operand_t prev_in1;
    alu_operand_t prev_in2;
    logic         prev_sub;
    logic [1:0]   prev_op;
    logic [1:0]   prev_logic;
    ls_offset_t   prev_offset;
    word_t        prev_base;
    word_t        prev_sdata;
    logic [1:0]   prev_kind;
    word_t        prev_shifter;   // taken from the presented word
    logic         prev_arith;
    logic         prev_lshift;
    fn3_t         prev_fn3;

    task automatic compare_value(input string what, input logic [79:0] got,
                                 input logic [79:0] expected, inout int count);
        if (got !== expected) begin
            count++;
            $display("CHECK FAILED at %0d ns: %s is %0h, expected %0h",
                     $time, what, got, expected);
        end
    endtask

    // left shifts enter the shifter bit reversed
    function automatic word_t shifter_input(input instr_t instr, input word_t rs1);
        word_t reversed;
        reversed = {<<{rs1}};
        return (instr[14:12] == fn3_sll) ? reversed : rs1;
    endfunction

    // only an arithmetic right shift fills with the sign of rs1
    function automatic logic shift_fill(input instr_t instr, input word_t rs1);
        return (instr[14:12] == fn3_sra) && instr[30] && rs1[xlen-1];
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            issue_errors = 0;
            operand_errors = 0;
            prev_issue <= '0;
        end else begin
            compare_value("rs1_addr", 80'(rs1_addr), 80'(instruction[19:15]), issue_errors);
            compare_value("rs2_addr", 80'(rs2_addr), 80'(instruction[24:20]), issue_errors);
            compare_value("pop", 80'(pop), 80'(exp_pop), issue_errors);
            compare_value("issue", 80'(issue), 80'(exp_issue), issue_errors);
            compare_value("illegal", 80'(illegal), 80'(exp_illegal), issue_errors);
            compare_value("start", 80'(start), 80'(prev_issue), issue_errors);
            if (prev_issue[unit_alu]) begin
                compare_value("alu_in1", 80'(alu_in1), 80'(prev_in1), operand_errors);
                compare_value("alu_in2", 80'(alu_in2), 80'(prev_in2), operand_errors);
                compare_value("alu_subtract", 80'(alu_subtract), 80'(prev_sub),
                              operand_errors);
                compare_value("alu_op", 80'(alu_op), 80'(prev_op), operand_errors);
                compare_value("alu_logic", 80'(alu_logic), 80'(prev_logic), operand_errors);
                if (prev_op == op_shift) begin
                    compare_value("alu_shifter_in", 80'(alu_shifter_in), 80'(prev_shifter),
                                  operand_errors);
                    compare_value("alu_arith", 80'(alu_arith), 80'(prev_arith),
                                  operand_errors);
                    compare_value("alu_lshift", 80'(alu_lshift), 80'(prev_lshift),
                                  operand_errors);
                end
            end
            if (prev_issue[unit_ls]) begin
                compare_value("ls_offset", 80'(ls_offset), 80'(prev_offset), operand_errors);
                compare_value("ls_base", 80'(ls_base), 80'(prev_base), operand_errors);
                compare_value("ls_store_data", 80'(ls_store_data), 80'(prev_sdata),
                              operand_errors);
                compare_value("ls_fn3", 80'(ls_fn3), 80'(prev_fn3), operand_errors);
                compare_value("ls kind", 80'({ls_load, ls_store}), 80'(prev_kind),
                              operand_errors);
            end
            prev_issue   <= exp_issue;
            prev_in1     <= exp_in1;
            prev_in2     <= exp_in2;
            prev_sub     <= exp_sub;
            prev_op      <= exp_op;
            prev_logic   <= exp_logic;
            prev_offset  <= exp_offset;
            prev_base    <= exp_base;
            prev_sdata   <= exp_sdata;
            prev_kind    <= exp_kind;
            prev_shifter <= shifter_input(instruction, rs1_data);
            prev_arith   <= shift_fill(instruction, rs1_data);
            prev_lshift  <= (instruction[14:12] == fn3_sll);
            prev_fn3     <= instruction[14:12];
        end
    end

endmodule

// ==== bench/decode_assert.sv ====
//----------------------------------------------------------------------
// assertions on the issue strobes and reset behavior of decode_issue
//----------------------------------------------------------------------
module decode_assert (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pop,
    input  decode_pkg::unit_vec_t issue,
    input  decode_pkg::unit_vec_t start
);
    timeunit 1ns;
    timeprecision 1ps;

    issue_one_hot: assert property (@(posedge clk) disable iff (rst) $onehot0(issue))
        else $error("issue selects more than one unit");

    pop_is_or_of_issue: assert property (@(posedge clk) pop == (|issue))
        else $error("pop does not match the OR of issue");

    // nothing leaves the stage while reset is held
    pop_low_in_reset: assert property (@(posedge clk) rst |-> !pop)
        else $error("pop high during reset");

    start_low_in_reset: assert property (@(posedge clk) rst |=> (start == '0))
        else $error("start pulse after a reset cycle");

endmodule

bind decode_issue decode_assert decode_assert_i (
    .clk   (clk),
    .rst   (rst),
    .pop   (pop),
    .issue (issue),
    .start (start)
);

// ==== rtl/decode_issue.sv ====
//----------------------------------------------------------------------
// decode and issue stage of the in-order RV32I core
//----------------------------------------------------------------------
module decode_issue (
    input  logic                      clk,
    input  logic                      rst,
    // instruction buffer
    input  logic                      instr_valid,
    input  decode_pkg::instr_t        instruction,
    input  decode_pkg::addr_t         pc,
    input  logic                      flush,
    // register file and scoreboard
    input  decode_pkg::word_t         rs1_data,
    input  decode_pkg::word_t         rs2_data,
    input  logic                      rs1_conflict,
    input  logic                      rs2_conflict,
    input  decode_pkg::unit_vec_t     unit_ready,
    output decode_pkg::reg_addr_t     rs1_addr,
    output decode_pkg::reg_addr_t     rs2_addr,
    // issue
    output logic                      pop,
    output decode_pkg::unit_vec_t     issue,
    output decode_pkg::unit_vec_t     start,
    output logic                      illegal,
    // ALU operands
    output decode_pkg::alu_operand_t  alu_in1,
    output decode_pkg::alu_operand_t  alu_in2,
    output decode_pkg::word_t         alu_shifter_in,
    output logic                      alu_subtract,
    output logic                      alu_arith,
    output logic                      alu_lshift,
    output decode_pkg::alu_logic_op_t alu_logic,
    output decode_pkg::alu_op_t       alu_op,
    // load-store operands
    output decode_pkg::ls_offset_t    ls_offset,
    output decode_pkg::word_t         ls_base,
    output decode_pkg::word_t         ls_store_data,
    output decode_pkg::fn3_t          ls_fn3,
    output logic                      ls_load,
    output logic                      ls_store
);
    import decode_pkg::*;

    reg_addr_t rd_addr;
    unit_vec_t unit_request;
    logic      uses_rs1;
    logic      uses_rs2;
    logic      uses_rd;
    logic      is_load;
    logic      is_store;

    assign rs1_addr = instruction[19:15];
    assign rs2_addr = instruction[24:20];
    assign rd_addr  = instruction[11:7];

    instr_classify classify_i (
        .instruction  (instruction),
        .unit_request (unit_request),
        .uses_rs1     (uses_rs1),
        .uses_rs2     (uses_rs2),
        .uses_rd      (uses_rd),
        .is_load      (is_load),
        .is_store     (is_store),
        .illegal      (illegal)
    );

    issue_control issue_ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .flush        (flush),
        .unit_request (unit_request),
        .uses_rs1     (uses_rs1),
        .uses_rs2     (uses_rs2),
        .uses_rd      (uses_rd),
        .is_load      (is_load),
        .is_store     (is_store),
        .rs2_addr     (rs2_addr),
        .rd_addr      (rd_addr),
        .rs1_conflict (rs1_conflict),
        .rs2_conflict (rs2_conflict),
        .unit_ready   (unit_ready),
        .issue        (issue),
        .pop          (pop),
        .start        (start)
    );

    alu_operand_prep alu_prep_i (
        .clk            (clk),
        .issue_alu      (issue[unit_alu]),
        .instruction    (instruction),
        .pc             (pc),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .alu_in1        (alu_in1),
        .alu_in2        (alu_in2),
        .alu_shifter_in (alu_shifter_in),
        .alu_subtract   (alu_subtract),
        .alu_arith      (alu_arith),
        .alu_lshift     (alu_lshift),
        .alu_logic      (alu_logic),
        .alu_op         (alu_op)
    );

    ls_operand_prep ls_prep_i (
        .clk           (clk),
        .issue_ls      (issue[unit_ls]),
        .instruction   (instruction),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .ls_offset     (ls_offset),
        .ls_base       (ls_base),
        .ls_store_data (ls_store_data),
        .ls_fn3        (ls_fn3),
        .ls_load       (ls_load),
        .ls_store      (ls_store)
    );

endmodule

// ==== rtl/ls_operand_prep.sv ====
//----------------------------------------------------------------------
// load-store operand preparation, registered on LS issue
//----------------------------------------------------------------------
module ls_operand_prep (
    input  logic                   clk,
    input  logic                   issue_ls,
    input  decode_pkg::instr_t     instruction,
    input  decode_pkg::word_t      rs1_data,
    input  decode_pkg::word_t      rs2_data,
    output decode_pkg::ls_offset_t ls_offset,
    output decode_pkg::word_t      ls_base,
    output decode_pkg::word_t      ls_store_data,
    output decode_pkg::fn3_t       ls_fn3,
    output logic                   ls_load,
    output logic                   ls_store
);
    import decode_pkg::*;

    opcode_trim_t trim;
    logic         store_op;
    logic         load_op;
    ls_offset_t   offset;

    assign trim     = opcode_trim_t'(instruction[6:2]);
    assign store_op = (trim == opc_store);
    assign load_op  = (trim == opc_load);

    // store immediate is split around rs2
    assign offset = store_op ? {instruction[31:25], instruction[11:7]} : instruction[31:20];

    always_ff @(posedge clk) begin
        if (issue_ls) begin
            ls_offset     <= offset;
            ls_base       <= rs1_data;
            ls_store_data <= rs2_data;
            ls_fn3        <= instruction[14:12];   // access size and sign
            ls_load       <= load_op;
            ls_store      <= store_op;
        end
    end

endmodule

// ==== rtl/alu_operand_prep.sv ====
//----------------------------------------------------------------------
// ALU operand preparation
// selects operands and control, registered on ALU issue
//----------------------------------------------------------------------
module alu_operand_prep (
    input  logic                      clk,
    input  logic                      issue_alu,
    input  decode_pkg::instr_t        instruction,
    input  decode_pkg::addr_t         pc,
    input  decode_pkg::word_t         rs1_data,
    input  decode_pkg::word_t         rs2_data,
    output decode_pkg::alu_operand_t  alu_in1,
    output decode_pkg::alu_operand_t  alu_in2,
    output decode_pkg::word_t         alu_shifter_in,
    output logic                      alu_subtract,
    output logic                      alu_arith,
    output logic                      alu_lshift,
    output decode_pkg::alu_logic_op_t alu_logic,
    output decode_pkg::alu_op_t       alu_op
);
    import decode_pkg::*;

    opcode_trim_t  trim;
    fn3_t          fn3;
    logic          upper_imm;      // lui or auipc
    logic          unsigned_cmp;
    word_t         in1_data;
    word_t         in2_data;
    word_t         rs1_reversed;
    logic          subtract;
    alu_logic_op_t logic_sel;
    alu_op_t       op_sel;

    assign trim      = opcode_trim_t'(instruction[6:2]);
    assign fn3       = instruction[14:12];
    assign upper_imm = (trim == opc_lui) || (trim == opc_auipc);

    // first operand
    assign in1_data = (trim == opc_lui) ? '0 : (trim == opc_auipc) ? pc : rs1_data;

    // second operand
    always_comb begin
        if (upper_imm)
            in2_data = {instruction[31:12], 12'b0};
        else if (trim == opc_arith_imm)
            in2_data = {{(xlen-12){instruction[31]}}, instruction[31:20]};
        else
            in2_data = rs2_data;
    end

    // sub for SUB and both compares, never for the upper immediates
    assign subtract = ~upper_imm &
                      ((fn3 inside {fn3_slt, fn3_sltu}) ||
                       ((fn3 == fn3_add_sub) && (trim == opc_arith) && instruction[30]));

    assign unsigned_cmp = ~upper_imm & (fn3 == fn3_sltu);

    always_comb begin
        case (fn3)
            fn3_xor: logic_sel = logic_xor;
            fn3_or:  logic_sel = logic_or;
            fn3_and: logic_sel = logic_and;
            default: logic_sel = logic_add;
        endcase
    end

    always_comb begin
        case (fn3)
            fn3_slt, fn3_sltu: op_sel = op_slt;
            fn3_sll, fn3_sra:  op_sel = op_shift;
            default:           op_sel = op_add_sub;
        endcase
    end

    // left shifts run through the right shifter on reversed bits
    always_comb begin
        for (int i = 0; i < xlen; i++)
            rs1_reversed[i] = rs1_data[xlen-1-i];
    end

    always_ff @(posedge clk) begin
        if (issue_alu) begin
            alu_in1        <= {in1_data[xlen-1] & ~unsigned_cmp, in1_data};
            alu_in2        <= {in2_data[xlen-1] & ~unsigned_cmp, in2_data};
            alu_shifter_in <= fn3[2] ? rs1_data : rs1_reversed;
            alu_subtract   <= subtract;
            alu_arith      <= rs1_data[xlen-1] & instruction[30];   // bit shifted in
            alu_lshift     <= ~fn3[2];
            alu_logic      <= upper_imm ? logic_add : logic_sel;
            alu_op         <= upper_imm ? op_add_sub : op_sel;
        end
    end

endmodule

// ==== rtl/issue_control.sv ====
//----------------------------------------------------------------------
// issue control
// hazard check, load to store forwarding and per-unit issue strobes
//----------------------------------------------------------------------
module issue_control (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instr_valid,
    input  logic                  flush,
    input  decode_pkg::unit_vec_t unit_request,
    input  logic                  uses_rs1,
    input  logic                  uses_rs2,
    input  logic                  uses_rd,
    input  logic                  is_load,
    input  logic                  is_store,
    input  decode_pkg::reg_addr_t rs2_addr,
    input  decode_pkg::reg_addr_t rd_addr,
    input  logic                  rs1_conflict,
    input  logic                  rs2_conflict,
    input  decode_pkg::unit_vec_t unit_ready,
    output decode_pkg::unit_vec_t issue,
    output logic                  pop,
    output decode_pkg::unit_vec_t start
);
    import decode_pkg::*;

    reg_addr_t load_rd;        // rd of the last issued load
    logic      load_rd_valid;
    logic      issue_valid;
    logic      single_request;
    logic      store_forward;
    logic      operands_ready;
    unit_vec_t ready_request;

    assign issue_valid = instr_valid & ~flush;

    // exactly one unit, guards against a decode that maps to none or several
    assign single_request = (unit_request != '0) &&
                            ((unit_request & (unit_request - 1'b1)) == '0);

    //------------------------------------------------------------------
    // operand readiness
    //------------------------------------------------------------------
    // the LS unit forwards load data into a following store's rs2
    assign store_forward = is_store & load_rd_valid & (rs2_addr == load_rd);

    assign operands_ready = ~((uses_rs1 & rs1_conflict) |
                              (uses_rs2 & rs2_conflict & ~store_forward));

    assign ready_request = unit_request & unit_ready;

    assign issue = (issue_valid & single_request & operands_ready) ? ready_request : '0;
    assign pop   = |issue;

    //------------------------------------------------------------------
    // forwarding tracker
    //------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (pop && is_load)
            load_rd <= rd_addr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            load_rd_valid <= 1'b0;
        end else if (pop) begin
            if (is_load)
                load_rd_valid <= uses_rd;   // load to x0 has nothing to forward
            else if (uses_rd && (rd_addr == load_rd))
                load_rd_valid <= 1'b0;      // register overwritten since the load
        end
    end

    // start pulse one cycle after issue
    always_ff @(posedge clk) begin
        if (rst)
            start <= '0;
        else
            start <= issue;
    end

endmodule

// ==== rtl/instr_classify.sv ====
//----------------------------------------------------------------------
// instruction classifier
// maps the opcode to a unit request, register usage and illegal flag
//----------------------------------------------------------------------
module instr_classify (
    input  decode_pkg::instr_t    instruction,
    output decode_pkg::unit_vec_t unit_request,
    output logic                  uses_rs1,
    output logic                  uses_rs2,
    output logic                  uses_rd,
    output logic                  is_load,
    output logic                  is_store,
    output logic                  illegal
);
    import decode_pkg::*;

    opcode_trim_t trim;
    logic         low_bits_ok;
    logic         known;
    logic         mul_div;
    logic         rd_zero;

    assign trim        = opcode_trim_t'(instruction[6:2]);
    assign low_bits_ok = (instruction[1:0] == 2'b11);
    assign mul_div     = (trim == opc_arith) && instruction[25];   // M extension not present
    assign rd_zero     = (instruction[11:7] == 5'd0);

    assign known = trim inside {opc_lui, opc_auipc, opc_jal, opc_jalr, opc_branch,
                                opc_load, opc_store, opc_arith, opc_arith_imm,
                                opc_fence, opc_system};

    assign illegal = ~low_bits_ok | ~known | mul_div;

    // illegal words request nothing so they can never issue
    always_comb begin
        unit_request              = '0;
        unit_request[unit_alu]    = (trim inside {opc_lui, opc_auipc, opc_arith_imm}) ||
                                    ((trim == opc_arith) && ~instruction[25]);
        unit_request[unit_ls]     = trim inside {opc_load, opc_store};
        unit_request[unit_branch] = trim inside {opc_branch, opc_jal, opc_jalr};
        unit_request[unit_env]    = trim inside {opc_fence, opc_system};
        if (illegal)
            unit_request = '0;
    end

    assign is_load  = low_bits_ok && (trim == opc_load);
    assign is_store = low_bits_ok && (trim == opc_store);

    // register usage
    assign uses_rs1 = trim inside {opc_jalr, opc_branch, opc_load, opc_store,
                                   opc_arith, opc_arith_imm};
    assign uses_rs2 = trim inside {opc_branch, opc_store, opc_arith};
    assign uses_rd  = ~rd_zero && (trim inside {opc_lui, opc_auipc, opc_jal, opc_jalr,
                                                opc_load, opc_arith, opc_arith_imm});

endmodule

// ==== rtl/decode_pkg.sv ====
//----------------------------------------------------------------------
// decode package for the RV32I decode and issue stage
// widths, trimmed opcodes, funct3 codes, unit indices and ALU enums
//----------------------------------------------------------------------
package decode_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [2:0] fn3_t;
    typedef logic [11:0] ls_offset_t;
    typedef logic [xlen:0] alu_operand_t;   // word plus sign bit for slt

    //------------------------------------------------------------------
    // opcodes, bits 6:2 only (bits 1:0 must be 2'b11)
    //------------------------------------------------------------------
    typedef enum logic [4:0] {
        opc_lui       = 5'b01101,
        opc_auipc     = 5'b00101,
        opc_jal       = 5'b11011,
        opc_jalr      = 5'b11001,
        opc_branch    = 5'b11000,
        opc_load      = 5'b00000,
        opc_store     = 5'b01000,
        opc_arith     = 5'b01100,
        opc_arith_imm = 5'b00100,
        opc_fence     = 5'b00011,
        opc_system    = 5'b11100
    } opcode_trim_t;

    // funct3 of the integer ops
    localparam fn3_t fn3_add_sub = 3'b000;
    localparam fn3_t fn3_sll     = 3'b001;
    localparam fn3_t fn3_slt     = 3'b010;
    localparam fn3_t fn3_sltu    = 3'b011;
    localparam fn3_t fn3_xor     = 3'b100;
    localparam fn3_t fn3_sra     = 3'b101;   // srl shares this code
    localparam fn3_t fn3_or      = 3'b110;
    localparam fn3_t fn3_and     = 3'b111;

    //------------------------------------------------------------------
    // execution units
    //------------------------------------------------------------------
    localparam int num_units   = 4;
    localparam int unit_alu    = 0;
    localparam int unit_ls     = 1;
    localparam int unit_branch = 2;
    localparam int unit_env    = 3;   // system and fence

    typedef logic [num_units-1:0] unit_vec_t;

    // ALU result path
    typedef enum logic [1:0] {
        op_add_sub = 2'b00,
        op_slt     = 2'b01,
        op_shift   = 2'b10
    } alu_op_t;

    // ALU logic path, add leaves the adder result untouched
    typedef enum logic [1:0] {
        logic_add = 2'b00,
        logic_xor = 2'b01,
        logic_or  = 2'b10,
        logic_and = 2'b11
    } alu_logic_op_t;

endpackage
